// ==== hw/acc_lane.sv ====
//////////////////////////////
// one lane of bin sums with read modify write
// a bin is undefined until its first pass is written
// a bin must not be hit on two beats in a row
//////////////////////////////
`default_nettype none

module acc_lane #(
  parameter int IDX = 0  // which sample of ctl.smp
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clr,      // sync clear
  // beat control from the sequencer
  lane_ctl_if.lane                   ctl,
  // read-only memory port
  input  logic                       bus_ren,
  input  logic [sig_avg_pkg::AW-1:0] bus_adr,
  output logic [sig_avg_pkg::RW-1:0] rd_dat,   // one edge after bus_ren
  // results on the final pass
  output logic                       res_vld,
  output logic [sig_avg_pkg::RW-1:0] res_dat,
  output logic                       res_eof
);

  //////////////////////////////
  // local signals
  //////////////////////////////
  logic [sig_avg_pkg::RW-1:0] mem [0:sig_avg_pkg::BINS-1];  // bin sums

  logic [sig_avg_pkg::RW-1:0] mem_rdt;  // old sum of the bin
  logic                       wen;      // write stage busy
  logic [sig_avg_pkg::AW-1:0] wad;      // bin to write
  logic                       w_first;  // ignore old sum
  logic                       w_last;   // flag as result
  logic                       w_eof;
  logic [sig_avg_pkg::SW-1:0] smp_q;    // this lane's sample
  logic [sig_avg_pkg::RW-1:0] smp_ext;  // sign extended
  logic [sig_avg_pkg::RW-1:0] wdt;      // new sum

  //////////////////////////////
  // read stage
  //////////////////////////////

  // fetch the running sum as the beat is accepted
  always_ff @(posedge clk) begin
    if (ctl.acc) begin
      mem_rdt <= mem[ctl.adr];
    end
  end

  // write stage follows one cycle later
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      wen <= 1'b0;
    end else begin
      wen <= ctl.acc;
    end
  end

  // address, flags and sample ride along
  always_ff @(posedge clk) begin
    if (ctl.acc) begin
      wad     <= ctl.adr;
      w_first <= ctl.first;
      w_last  <= ctl.last;
      w_eof   <= ctl.eof;
      smp_q   <= ctl.smp[IDX];
    end
  end

  //////////////////////////////
  // write stage
  //////////////////////////////
  assign smp_ext = {{(sig_avg_pkg::RW - sig_avg_pkg::SW){smp_q[sig_avg_pkg::SW-1]}}, smp_q};
  assign wdt     = smp_ext + (w_first ? '0 : mem_rdt);  // first pass starts at zero

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[wad] <= wdt;
    end
  end

  // result leaves together with the write
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      res_vld <= 1'b0;
    end else begin
      res_vld <= wen & w_last;
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      res_dat <= wdt;
      res_eof <= w_eof;
    end
  end

  // bus read port, held between reads
  always_ff @(posedge clk) begin
    if (bus_ren) begin
      rd_dat <= mem[bus_adr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/frame_sequencer.sv ====
//////////////////////////////
// input handshake, bin address and pass count
// frames must be 2 to BINS beats long
// cfg_cnt must not change while a run is in progress
//////////////////////////////
`default_nettype none

module frame_sequencer (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               clr,         // sync clear
  // configuration
  input  logic [sig_avg_pkg::CW-1:0]                         cfg_cnt,     // passes minus one
  // input stream
  input  logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::SW-1:0] sti_tdata,
  input  logic                                               sti_tlast,
  input  logic                                               sti_tvalid,
  output logic                                               sti_tready,
  // status
  output logic [sig_avg_pkg::CW-1:0]                         sts_cnt,     // passes done
  output logic                                               sts_end,     // run finished
  // lane control
  lane_ctl_if.seq                                            ctl
);

  //////////////////////////////
  // local signals
  //////////////////////////////
  logic                       trn;       // beat accepted this cycle
  logic [sig_avg_pkg::AW-1:0] adr;       // bin address counter
  logic [sig_avg_pkg::CW-1:0] cnt;       // pass counter
  logic                       pass_beg;  // first pass of a run
  logic                       pass_end;  // final pass of a run

  //////////////////////////////
  // handshake
  //////////////////////////////

  // only a clear holds off the source
  assign sti_tready = ~clr;
  assign trn        = sti_tvalid & sti_tready;

  //////////////////////////////
  // bin address
  //////////////////////////////

  // one bin per beat, restart at frame end
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      adr <= '0;
    end else if (trn) begin
      adr <= sti_tlast ? '0 : adr + 1'b1;
    end
  end

  //////////////////////////////
  // pass counter
  //////////////////////////////

  // steps once per frame
  // wraps after the final pass so the next run starts clean
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      cnt <= '0;
    end else if (trn && sti_tlast) begin
      cnt <= pass_end ? '0 : cnt + 1'b1;
    end
  end

  // flags decided once here for all lanes
  assign pass_beg = (cnt == '0);
  assign pass_end = (cnt == cfg_cnt);  // also true on pass 0 when cfg_cnt is 0

  //////////////////////////////
  // status
  //////////////////////////////
  assign sts_cnt = cnt;
  assign sts_end = trn & sti_tlast & pass_end;  // pulse on last beat of final pass

  //////////////////////////////
  // lane control, straight from the accepted beat
  //////////////////////////////
  assign ctl.acc   = trn;
  assign ctl.adr   = adr;
  assign ctl.smp   = sti_tdata;
  assign ctl.first = pass_beg;
  assign ctl.last  = pass_end;
  assign ctl.eof   = sti_tlast;

endmodule

`default_nettype wire

// ==== hw/lane_ctl_if.sv ====
//////////////////////////////
// per beat control from the sequencer to every lane
// all fields are combinational and valid only while acc is high
//////////////////////////////
`default_nettype none

interface lane_ctl_if;

  //////////////////////////////
  // beat strobe and address
  //////////////////////////////
  logic                                               acc;    // accepted beat
  logic [sig_avg_pkg::AW-1:0]                         adr;    // bin of this beat

  // all lanes travel together, each lane picks its own
  logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::SW-1:0] smp;

  //////////////////////////////
  // pass and frame flags
  //////////////////////////////
  logic                                               first;  // start sums from zero
  logic                                               last;   // final pass
  logic                                               eof;    // last beat of frame

  // sequencer side
  modport seq (
    output acc,
    output adr,
    output smp,
    output first,
    output last,
    output eof
  );

  // lane side, listen only
  modport lane (
    input  acc,
    input  adr,
    input  smp,
    input  first,
    input  last,
    input  eof
  );

endinterface

`default_nettype wire

// ==== hw/result_collector.sv ====
//////////////////////////////
// gathers lane results into one output beat
// lanes run in lockstep so lane 0 flags stand for all
// no back-pressure on the output
//////////////////////////////
`default_nettype none

module result_collector (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               clr,      // sync clear
  // lane results
  input  logic [sig_avg_pkg::LANES-1:0]                      res_vld,
  input  logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] res_dat,
  input  logic [sig_avg_pkg::LANES-1:0]                      res_eof,
  // lane bus reads
  input  logic                                               bus_ren,
  input  logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] rd_dat,
  // output stream
  output logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] sto_tdata,
  output logic                                               sto_tlast,
  output logic                                               sto_tvalid,
  // bus read data
  output logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] bus_rdt
);

  logic ren_q;  // lane read words land this cycle

  //////////////////////////////
  // output stream
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      sto_tvalid <= 1'b0;
    end else begin
      sto_tvalid <= res_vld[0];
    end
  end

  always_ff @(posedge clk) begin
    if (res_vld[0]) begin
      sto_tdata <= res_dat;
      sto_tlast <= res_eof[0];  // frame end
    end
  end

  //////////////////////////////
  // bus read gather
  //////////////////////////////

  // lanes answer one edge after bus_ren
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      ren_q <= 1'b0;
    end else begin
      ren_q <= bus_ren;
    end
  end

  always_ff @(posedge clk) begin
    if (ren_q) begin
      bus_rdt <= rd_dat;  // held until the next read
    end
  end

endmodule

`default_nettype wire

// ==== hw/sig_avg_pkg.sv ====
//////////////////////////////
// widths and sizes shared by the averager
// BINS must be a power of two
// sums carry CW bits of headroom over one sample
//////////////////////////////
`default_nettype none

package sig_avg_pkg;

  //////////////////////////////
  // input stream shape
  //////////////////////////////
  localparam int LANES = 2;   // samples per beat
  localparam int SW    = 14;  // signed sample width

  //////////////////////////////
  // accumulation
  //////////////////////////////
  localparam int CW    = 16;            // pass counter width
  localparam int BINS  = 256;           // longest frame in beats
  localparam int AW    = $clog2(BINS);  // bin address width

  // a sum of 2**CW full scale samples still fits
  localparam int RW    = SW + CW;

endpackage

`default_nettype wire

// ==== hw/sig_avg_top.sv ====
//////////////////////////////
// streaming averager over cfg_cnt+1 frames
// frames 2 to BINS beats, output strobe has no ready
// results two edges after the accepted beat
//////////////////////////////
`default_nettype none

module sig_avg_top (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               clr,         // sync clear
  // configuration
  input  logic [sig_avg_pkg::CW-1:0]                         cfg_cnt,     // passes minus one
  // input stream
  input  logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::SW-1:0] sti_tdata,
  input  logic                                               sti_tlast,
  input  logic                                               sti_tvalid,
  output logic                                               sti_tready,
  // output stream
  output logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] sto_tdata,
  output logic                                               sto_tlast,
  output logic                                               sto_tvalid,
  // status
  output logic [sig_avg_pkg::CW-1:0]                         sts_cnt,
  output logic                                               sts_end,
  // read-only memory port
  input  logic                                               bus_ren,
  input  logic [sig_avg_pkg::AW-1:0]                         bus_adr,
  output logic [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] bus_rdt
);

  //////////////////////////////
  // lane wiring
  //////////////////////////////
  lane_ctl_if ctl ();

  wire [sig_avg_pkg::LANES-1:0]                      res_vld;
  wire [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] res_dat;
  wire [sig_avg_pkg::LANES-1:0]                      res_eof;
  wire [sig_avg_pkg::LANES-1:0][sig_avg_pkg::RW-1:0] rd_dat;

  frame_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .clr        (clr),
    .cfg_cnt    (cfg_cnt),
    .sti_tdata  (sti_tdata),
    .sti_tlast  (sti_tlast),
    .sti_tvalid (sti_tvalid),
    .sti_tready (sti_tready),
    .sts_cnt    (sts_cnt),
    .sts_end    (sts_end),
    .ctl        (ctl.seq)
  );

  // one accumulator per sample lane
  for (genvar i = 0; i < sig_avg_pkg::LANES; i++) begin : g_lane
    acc_lane #(
      .IDX (i)
    ) u_lane (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .ctl     (ctl.lane),
      .bus_ren (bus_ren),
      .bus_adr (bus_adr),
      .rd_dat  (rd_dat[i]),
      .res_vld (res_vld[i]),
      .res_dat (res_dat[i]),
      .res_eof (res_eof[i])
    );
  end

  result_collector u_col (
    .clk        (clk),
    .rst        (rst),
    .clr        (clr),
    .res_vld    (res_vld),
    .res_dat    (res_dat),
    .res_eof    (res_eof),
    .bus_ren    (bus_ren),
    .rd_dat     (rd_dat),
    .sto_tdata  (sto_tdata),
    .sto_tlast  (sto_tlast),
    .sto_tvalid (sto_tvalid),
    .bus_rdt    (bus_rdt)
  );

endmodule

`default_nettype wire

// ==== sig_avg.f ====
hw/sig_avg_pkg.sv
hw/lane_ctl_if.sv
hw/frame_sequencer.sv
hw/acc_lane.sv
hw/result_collector.sv
hw/sig_avg_top.sv
test/sig_avg_tb.sv

// ==== test/sig_avg_tb.sv ====
//////////////////////////////
// testbench for the streaming averager
// reference model keeps a sum per bin and lane
// frames stay 2 to BINS beats, cfg_cnt changes only between runs
//////////////////////////////
`default_nettype none

module sig_avg_tb;

  localparam int LANES = sig_avg_pkg::LANES;
  localparam int SW    = sig_avg_pkg::SW;
  localparam int CW    = sig_avg_pkg::CW;
  localparam int BINS  = sig_avg_pkg::BINS;
  localparam int AW    = sig_avg_pkg::AW;
  localparam int RW    = sig_avg_pkg::RW;

  //////////////////////////////
  // run length for the watchdog
  //////////////////////////////
  localparam int PER     = 4;  // clock period
  localparam int BEATS   = 2*8 + 4*16 + 3*2 + 17 + 3*12 + 6*20 + 2*BINS;
  localparam int READS   = 8 + 16 + 2 + 12 + 20 + BINS;
  localparam int WD_TIME = (3*BEATS + READS + 400) * PER;  // gaps up to 2 idle cycles per beat

  logic                          clk;
  logic                          rst;
  logic                          clr;
  logic [CW-1:0]                 cfg_cnt;
  logic [LANES-1:0][SW-1:0]      sti_tdata;
  logic                          sti_tlast;
  logic                          sti_tvalid;
  logic                          sti_tready;
  logic [LANES-1:0][RW-1:0]      sto_tdata;
  logic                          sto_tlast;
  logic                          sto_tvalid;
  logic [CW-1:0]                 sts_cnt;
  logic                          sts_end;
  logic                          bus_ren;
  logic [AW-1:0]                 bus_adr;
  logic [LANES-1:0][RW-1:0]      bus_rdt;

  //////////////////////////////
  // reference model state
  //////////////////////////////
  string                         tname;                    // current test
  int                            err_dat = 0;
  int                            err_sts = 0;
  int                            err_bus = 0;
  int                            err_oth = 0;
  longint                        sums [0:BINS-1][0:LANES-1];  // signed bin sums
  int unsigned                   bin_m;                    // next bin
  logic [CW-1:0]                 pass_m;                   // passes done
  logic                          exp_v [0:2];              // output pipe, oldest last
  logic                          exp_l [0:2];
  logic [LANES-1:0][RW-1:0]      exp_d [0:2];
  logic                          br_v [0:1];               // bus read pipe
  logic [AW-1:0]                 br_a [0:1];

  sig_avg_top dut (
    .clk        (clk),
    .rst        (rst),
    .clr        (clr),
    .cfg_cnt    (cfg_cnt),
    .sti_tdata  (sti_tdata),
    .sti_tlast  (sti_tlast),
    .sti_tvalid (sti_tvalid),
    .sti_tready (sti_tready),
    .sto_tdata  (sto_tdata),
    .sto_tlast  (sto_tlast),
    .sto_tvalid (sto_tvalid),
    .sts_cnt    (sts_cnt),
    .sts_end    (sts_end),
    .bus_ren    (bus_ren),
    .bus_adr    (bus_adr),
    .bus_rdt    (bus_rdt)
  );

  always #(PER/2) clk = ~clk;

  // sums of one bin as the DUT packs them
  function automatic logic [LANES-1:0][RW-1:0] bin_word(input int unsigned a);
    logic [LANES-1:0][RW-1:0] w;
    longint                   v;
    for (int l = 0; l < LANES; l++) begin
      v    = sums[a][l];
      w[l] = v[RW-1:0];  // sums never exceed RW bits
    end
    return w;
  endfunction

  // drop everything in flight, sums stay
  task automatic flush_model();
    bin_m  = 0;
    pass_m = '0;
    for (int i = 0; i < 3; i++) begin
      exp_v[i] = 1'b0;
    end
    br_v[0] = 1'b0;
    br_v[1] = 1'b0;
  endtask

  //////////////////////////////
  // monitor and model, sampled at the rising edge
  //////////////////////////////
  always @(posedge clk) begin : mon
    logic acc;  // beat taken at this edge
    logic fin;  // final pass
    if (rst) begin
      flush_model();
    end else begin
      acc = sti_tvalid & ~clr;  // source held off only by a clear
      fin = (pass_m == cfg_cnt);
      // output strobe, two edges behind the accepted beat
      assert (sto_tvalid === exp_v[2]) else begin
        err_dat++;
        $display("FAILED %s sto_tvalid: expected %0b actual %0b", tname, exp_v[2], sto_tvalid);
      end
      if (exp_v[2]) begin
        assert (sto_tdata === exp_d[2]) else begin
          err_dat++;
          $display("FAILED %s sto_tdata: expected %h actual %h", tname, exp_d[2], sto_tdata);
        end
        assert (sto_tlast === exp_l[2]) else begin
          err_dat++;
          $display("FAILED %s sto_tlast: expected %0b actual %0b", tname, exp_l[2], sto_tlast);
        end
      end
      // status
      assert (sts_cnt === pass_m) else begin
        err_sts++;
        $display("FAILED %s sts_cnt: expected %0d actual %0d", tname, pass_m, sts_cnt);
      end
      assert (sts_end === (acc & sti_tlast & fin)) else begin
        err_sts++;
        $display("FAILED %s sts_end: expected %0b actual %0b", tname,
                 acc & sti_tlast & fin, sts_end);
      end
      // bus data, lane read then collector register
      if (br_v[1]) begin
        assert (bus_rdt === bin_word(br_a[1])) else begin
          err_bus++;
          $display("FAILED %s bus_rdt bin %0d: expected %h actual %h", tname, br_a[1],
                   bin_word(br_a[1]), bus_rdt);
        end
      end
      // advance pipes
      for (int i = 2; i > 0; i--) begin
        exp_v[i] = exp_v[i-1];
        exp_l[i] = exp_l[i-1];
        exp_d[i] = exp_d[i-1];
      end
      br_v[1]  = br_v[0];
      br_a[1]  = br_a[0];
      br_v[0]  = bus_ren;
      br_a[0]  = bus_adr;
      exp_v[0] = 1'b0;
      if (acc) begin
        for (int l = 0; l < LANES; l++) begin
          if (pass_m == '0) begin
            sums[bin_m][l] = $signed(sti_tdata[l]);  // first pass ignores old sum
          end else begin
            sums[bin_m][l] = sums[bin_m][l] + $signed(sti_tdata[l]);
          end
        end
        exp_v[0] = fin;  // results only on the final pass
        exp_l[0] = sti_tlast;
        exp_d[0] = bin_word(bin_m);
        if (sti_tlast) begin
          bin_m  = 0;
          pass_m = fin ? '0 : pass_m + 1'b1;
        end else begin
          bin_m++;
        end
      end
      if (clr) begin
        flush_model();
      end
    end
  end

  ready_follows_clr: assert property (@(posedge clk) disable iff (rst) sti_tready == !clr)
    else begin
      err_oth++;
      $display("FAILED %s sti_tready: expected %0b actual %0b", tname, !clr, sti_tready);
    end

  //////////////////////////////
  // stimulus, driven 1 unit after the edge
  //////////////////////////////
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_beat(input logic last);
    logic [31:0] rnd;
    for (int l = 0; l < LANES; l++) begin
      rnd          = $urandom();
      sti_tdata[l] = rnd[SW-1:0];  // full signed range
    end
    sti_tlast  = last;
    sti_tvalid = 1'b1;
    @(posedge clk);
    while (!sti_tready) @(posedge clk);
    #1;
    sti_tvalid = 1'b0;
    sti_tlast  = 1'b0;
  endtask

  task automatic run_frames(input string name, input int cnt, input int len,
                            input int frames, input bit gaps);
    tname   = name;
    cfg_cnt = cnt[CW-1:0];
    for (int f = 0; f < frames; f++) begin
      for (int b = 0; b < len; b++) begin
        if (gaps) begin
          idle($urandom() % 3);  // 0 to 2 idle cycles
        end
        send_beat(b == len - 1);
      end
    end
    idle(4);  // let the pipe drain
  endtask

  task automatic read_bins(input string name, input int len);
    tname = name;
    for (int a = 0; a < len; a++) begin
      bus_ren = 1'b1;
      bus_adr = a[AW-1:0];
      idle(1);
    end
    bus_ren = 1'b0;
    idle(3);
  endtask

  // partial run, then clear with valid held high
  task automatic clear_mid_run(input int cnt, input int len);
    tname   = "clear";
    cfg_cnt = cnt[CW-1:0];
    for (int b = 0; b < len + 5; b++) begin
      send_beat((b % len) == len - 1);
    end
    sti_tvalid = 1'b1;
    clr        = 1'b1;
    idle(3);
    assert (sts_cnt === '0) else begin
      err_sts++;
      $display("FAILED %s sts_cnt: expected 0 actual %0d", tname, sts_cnt);
    end
    clr        = 1'b0;
    sti_tvalid = 1'b0;
    idle(2);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin : main
    int unsigned seed_v;
    seed_v     = $urandom(32'h7744_a109);
    tname      = "reset";
    clk        = 1'b0;
    rst        = 1'b1;
    clr        = 1'b0;
    cfg_cnt    = '0;
    sti_tdata  = '0;
    sti_tlast  = 1'b0;
    sti_tvalid = 1'b0;
    bus_ren    = 1'b0;
    bus_adr    = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);
    run_frames("single_pass", 0, 8, 2, 1'b0);
    read_bins("single_read", 8);
    run_frames("multi_pass", 3, 16, 4, 1'b0);
    read_bins("multi_read", 16);
    run_frames("short_frame", 2, 2, 3, 1'b0);  // back to back bin reuse
    read_bins("short_read", 2);
    clear_mid_run(4, 12);
    run_frames("after_clear", 2, 12, 3, 1'b0);
    read_bins("clear_read", 12);
    run_frames("input_gaps", 5, 20, 6, 1'b1);
    read_bins("gaps_read", 20);
    run_frames("full_frame", 1, BINS, 2, 1'b0);
    read_bins("full_read", BINS);
    $display("errors: data %0d, status %0d, bus %0d, other %0d",
             err_dat, err_sts, err_bus, err_oth);
    if (err_dat + err_sts + err_bus + err_oth == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // hang guard
  initial begin : watchdog
    #(WD_TIME);
    $display("watchdog expired in %s before the tests finished", tname);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
